// ==== Bender.yml ====
package:
  name: acl_uart_reporter

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/acl_uart_pkg.sv
      - verilog/acl_readings_hold.sv
      - verilog/reading_hex_ascii.sv
      - verilog/uart_line_feed.sv
      - verilog/uart_tx_serial.sv
      - verilog/acl_uart_reporter.sv
  - target: test
    include_dirs:
      - verilog
      - dv
    files:
      - dv/tb_acl_uart_reporter.sv

// ==== dv/tb_uart_monitor.svh ====
/*
  UART byte receiver and expected text line builder
*/
`ifndef TB_UART_MONITOR_SVH
`define TB_UART_MONITOR_SVH

localparam int c_bit_cycles = `ACL_BAUD_DIV;
localparam int c_byte_cycles = 10 * `ACL_BAUD_DIV;          // Start, 8 data, stop
localparam logic [127:0] c_hex_chars = "0123456789ABCDEF";  // '0' in top byte

// Polls the serial line on falling edges until it goes low
task automatic wait_start_bit(input int max_cycles, output bit found);
  int n;
  found = 1'b0;
  n = 0;
  while (!found && (n < max_cycles)) begin
    @(negedge s_clk_20mhz);
    if (s_uart_tx == 1'b0) found = 1'b1;
    n++;
  end
endtask

// One 8N1 frame, sampled in the middle of each bit
task automatic receive_byte(output acl_uart_pkg::ascii_char_t data, output bit ok);
  bit found;
  ok = 1'b1;
  data = '0;
  wait_start_bit(2 * c_byte_cycles, found);
  if (!found) begin
    $display("ERROR %s: no UART start bit within %0d cycles", s_test_name, 2 * c_byte_cycles);
    note_error();
    ok = 1'b0;
  end else begin
    repeat (c_bit_cycles / 2) @(negedge s_clk_20mhz);  // Middle of start bit
    if (s_uart_tx !== 1'b0) begin
      $display("ERROR %s: start bit did not stay low", s_test_name);
      note_error();
    end
    for (int i = 0; i < 8; i++) begin
      repeat (c_bit_cycles) @(negedge s_clk_20mhz);
      data[i] = s_uart_tx;                              // LSB first
    end
    repeat (c_bit_cycles) @(negedge s_clk_20mhz);
    if (s_uart_tx !== 1'b1) begin
      $display("ERROR %s: stop bit low after byte 8'h%02h", s_test_name, data);
      note_error();
      ok = 1'b0;
    end
  end
endtask

// Receives bytes first .. first+count-1 of a line and compares them
task automatic receive_bytes(input acl_uart_pkg::uart_line_t exp_line,
                             input int first, input int count);
  acl_uart_pkg::ascii_char_t got;
  acl_uart_pkg::ascii_char_t want;
  bit ok;
  int i;
  ok = 1'b1;
  i = first;
  while (ok && (i < first + count)) begin
    receive_byte(got, ok);
    want = exp_line[(`ACL_LINE_BYTES - 1 - i) * 8 +: 8];  // First byte on top
    if (ok && (got !== want)) begin
      $display("CHECK FAILED %s byte %0d: expected 8'h%02h, actual 8'h%02h",
               s_test_name, i, want, got);
      note_error();
    end
    i++;
  end
endtask

function automatic acl_uart_pkg::ascii_char_t hex_char(input logic [3:0] nibble);
  return c_hex_chars[127 - nibble * 8 -: 8];
endfunction

// Fields X, Y, Z, T as upper-case hex, spaces between, CR LF at the end
function automatic acl_uart_pkg::uart_line_t expected_line(input acl_uart_pkg::readings_t r);
  acl_uart_pkg::uart_line_t line;
  line = '0;
  for (int f = 0; f < `ACL_FIELD_COUNT; f++) begin
    for (int d = 0; d < `ACL_HEX_DIGITS; d++) begin
      line = (line << 8) | hex_char(r[f * 16 + 12 - d * 4 +: 4]);  // MS nibble first
    end
    if (f < `ACL_FIELD_COUNT - 1) line = (line << 8) | 8'h20;
  end
  line = (line << 16) | 16'h0D0A;
  return line;
endfunction

`endif

// ==== dv/tb_acl_uart_reporter.sv ====
/*
  Testbench for the readings to UART text line path
  Clock, reset, DUT, directed tests and summary
*/
`timescale 1ns/1ps
`include "acl_uart_defs.svh"

module tb_acl_uart_reporter;

  logic s_clk_20mhz;
  logic s_rst_20mhz;
  acl_uart_pkg::readings_t s_readings;
  logic s_readings_valid;
  logic s_tx_go;
  logic s_uart_tx;
  logic s_line_busy;

  string  s_test_name;
  int     s_test_errors;
  int     s_pass_count;
  int     s_fail_count;
  integer s_seed;

  `include "tb_uart_monitor.svh"

  acl_uart_reporter dut_i (
    .i_clk            (s_clk_20mhz),
    .i_rst            (s_rst_20mhz),
    .i_readings       (s_readings),
    .i_readings_valid (s_readings_valid),
    .i_tx_go          (s_tx_go),
    .o_uart_tx        (s_uart_tx),
    .o_line_busy      (s_line_busy)
  );

  initial begin
    s_clk_20mhz = 1'b0;
    forever #25 s_clk_20mhz = ~s_clk_20mhz;  // 50 ns period
  end

  // Bookkeeping -----------------------------------------------
  task automatic note_error();
    s_test_errors++;
  endtask

  task automatic start_test(input string name);
    s_test_name = name;
    s_test_errors = 0;
  endtask

  task automatic finish_test();
    if (s_test_errors == 0) begin
      $display("test %s: ok", s_test_name);
      s_pass_count++;
    end else begin
      $display("test %s: %0d error(s)", s_test_name, s_test_errors);
      s_fail_count++;
    end
  endtask

  // Stimulus --------------------------------------------------
  task automatic load_readings(input acl_uart_pkg::readings_t r);
    @(posedge s_clk_20mhz);
    s_readings <= r;
    s_readings_valid <= 1'b1;
    @(posedge s_clk_20mhz);
    s_readings_valid <= 1'b0;
  endtask

  task automatic pulse_go();
    @(posedge s_clk_20mhz);
    s_tx_go <= 1'b1;
    @(posedge s_clk_20mhz);
    s_tx_go <= 1'b0;
  endtask

  // Busy rises the cycle after a go taken while idle
  task automatic check_busy_high();
    @(negedge s_clk_20mhz);
    if (s_line_busy !== 1'b1) begin
      $display("CHECK FAILED %s: expected busy=1, actual busy=%b", s_test_name, s_line_busy);
      note_error();
    end
  endtask

  task automatic wait_line_idle(input int max_cycles);
    int n;
    n = 0;
    while (s_line_busy && (n < max_cycles)) begin
      @(negedge s_clk_20mhz);
      n++;
    end
    if (s_line_busy) begin
      $display("ERROR %s: o_line_busy still high after %0d cycles", s_test_name, max_cycles);
      note_error();
    end
  endtask

  // Capture, settle through the converters, then send one line
  task automatic send_and_check_line(input acl_uart_pkg::readings_t r);
    load_readings(r);
    repeat (4) @(posedge s_clk_20mhz);
    pulse_go();
    check_busy_high();
    receive_bytes(expected_line(r), 0, `ACL_LINE_BYTES);
    wait_line_idle(2 * c_bit_cycles);
  endtask

  // Directed tests --------------------------------------------
  task automatic test_reset_idle();
    int bad;
    start_test("reset_idle");
    bad = 0;
    repeat (200) begin
      @(negedge s_clk_20mhz);
      if ((s_uart_tx !== 1'b1) || (s_line_busy !== 1'b0)) begin
        if (bad == 0) begin
          $display("CHECK FAILED %s: expected tx=1 busy=0, actual tx=%b busy=%b",
                   s_test_name, s_uart_tx, s_line_busy);
        end
        bad++;
      end
    end
    if (bad != 0) note_error();
    finish_test();
  endtask

  task automatic test_single_line();
    start_test("single_line");
    send_and_check_line({16'h09AB, 16'h0678, 16'h0345, 16'h0012});  // T, Z, Y, X
    finish_test();
  endtask

  task automatic test_hex_letters();
    start_test("hex_letters");
    send_and_check_line({16'h0000, 16'hFFFF, 16'hEF01, 16'hABCD});
    finish_test();
  endtask

  task automatic test_capture_blocked();
    acl_uart_pkg::readings_t r_first;
    acl_uart_pkg::readings_t r_late;
    start_test("capture_blocked");
    r_first = {16'h1111, 16'h2222, 16'h3333, 16'h4444};
    r_late = {16'hDEAD, 16'hBEEF, 16'hCAFE, 16'hF00D};
    load_readings(r_first);
    repeat (4) @(posedge s_clk_20mhz);
    pulse_go();
    check_busy_high();
    receive_bytes(expected_line(r_first), 0, 3);
    load_readings(r_late);                          // Lands mid-line, dropped
    receive_bytes(expected_line(r_first), 3, `ACL_LINE_BYTES - 3);
    wait_line_idle(2 * c_bit_cycles);
    repeat (4) @(posedge s_clk_20mhz);
    pulse_go();                                     // No new valid
    check_busy_high();
    receive_bytes(expected_line(r_first), 0, `ACL_LINE_BYTES);
    wait_line_idle(2 * c_bit_cycles);
    finish_test();
  endtask

  task automatic test_go_ignored();
    acl_uart_pkg::readings_t r;
    bit extra;
    start_test("go_ignored");
    r = {16'h7E57, 16'h0C0D, 16'hB00B, 16'h1234};
    load_readings(r);
    repeat (4) @(posedge s_clk_20mhz);
    pulse_go();
    check_busy_high();
    receive_bytes(expected_line(r), 0, 2);
    pulse_go();
    receive_bytes(expected_line(r), 2, 10);
    pulse_go();
    receive_bytes(expected_line(r), 12, `ACL_LINE_BYTES - 12);
    wait_line_idle(2 * c_bit_cycles);
    wait_start_bit(2 * c_byte_cycles, extra);     // Nothing may follow
    if (extra) begin
      $display("ERROR %s: start bit after the line ended", s_test_name);
      note_error();
    end
    finish_test();
  endtask

  task automatic test_random_readings();
    acl_uart_pkg::readings_t r;
    start_test("random_readings");
    for (int k = 0; k < 3; k++) begin
      r = {$random(s_seed), $random(s_seed)};
      send_and_check_line(r);
    end
    finish_test();
  endtask

  //----------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------
  initial begin
    s_rst_20mhz = 1'b1;
    s_readings = '0;
    s_readings_valid = 1'b0;
    s_tx_go = 1'b0;
    s_test_name = "";
    s_test_errors = 0;
    s_pass_count = 0;
    s_fail_count = 0;
    s_seed = 32'hcb63_4bcb;
    repeat (4) @(posedge s_clk_20mhz);
    s_rst_20mhz <= 1'b0;

    test_reset_idle();
    test_single_line();
    test_hex_letters();
    test_capture_blocked();
    test_go_ignored();
    test_random_readings();

    $display("tests passed: %0d, failed: %0d", s_pass_count, s_fail_count);
    if (s_fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_acl_uart_reporter

// ==== src.f ====
+incdir+verilog
+incdir+dv
verilog/acl_uart_pkg.sv
verilog/acl_readings_hold.sv
verilog/reading_hex_ascii.sv
verilog/uart_line_feed.sv
verilog/uart_tx_serial.sv
verilog/acl_uart_reporter.sv
dv/tb_acl_uart_reporter.sv

// ==== verilog/acl_readings_hold.sv ====
/*
  Measurement capture register
  Loads on a valid pulse only while no line is being sent
*/
`timescale 1ns/1ps

module acl_readings_hold (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  acl_uart_pkg::readings_t i_readings,       // Raw X, Y, Z, temp
  input  logic                   i_readings_valid, // One-cycle pulse
  input  logic                   i_line_busy,      // Line feed in transmission
  output acl_uart_pkg::readings_t o_readings        // Held set for conversion
);

  logic s_capture;

  // Drop, do not queue, a pulse that lands during a line
  assign s_capture = i_readings_valid & ~i_line_busy;

  //----------------------------------------------------------
  // Hold register
  //----------------------------------------------------------
  // Text under transmission never changes beneath the feed
  always_ff @(posedge i_clk) begin : p_hold
    if (i_rst) begin
      o_readings <= '0;                   // All fields read as zero
    end else if (s_capture) begin
      o_readings <= i_readings;           // Latest measurement set
    end
  end : p_hold

endmodule : acl_readings_hold

// ==== verilog/acl_uart_defs.svh ====
/*
  Shared macros for the reading to UART text path
  Clock rate, baud divisor, field count and line length
*/
`ifndef ACL_UART_DEFS_SVH
`define ACL_UART_DEFS_SVH

// Timing --------------------------------------------------
`define ACL_FCLK        20000000     // System clock in Hz
`define ACL_BAUD        115200       // UART line rate

// Clocks per UART bit, rounded to nearest
`define ACL_BAUD_DIV    ((`ACL_FCLK + (`ACL_BAUD / 2)) / `ACL_BAUD)

// Line format ---------------------------------------------
`define ACL_FIELD_COUNT 4            // X, Y, Z, temperature
`define ACL_HEX_DIGITS  4            // Hex chars per reading

// 16 hex chars, 3 spaces, CR and LF
`define ACL_LINE_BYTES  21

`endif

// ==== verilog/acl_uart_pkg.sv ====
/*
  Types for the reading to UART text path
  Vector typedefs and the two state enums
*/
`include "acl_uart_defs.svh"

package acl_uart_pkg;

  // Vector types ------------------------------------------
  typedef logic [15:0] reading_t;                              // One sensor reading
  typedef logic [`ACL_FIELD_COUNT*16-1:0] readings_t;          // X in low bits, temp on top
  typedef logic [7:0] ascii_char_t;                            // One character
  typedef logic [`ACL_HEX_DIGITS*8-1:0] ascii_field_t;         // First char in top byte
  typedef logic [`ACL_LINE_BYTES*8-1:0] uart_line_t;           // First byte in top byte

  // State machines ----------------------------------------
  typedef enum logic [1:0] {
    feed_idle, feed_load, feed_send, feed_wait
  } feed_state_t;

  typedef enum logic [1:0] {
    tx_idle, tx_start, tx_data, tx_stop
  } tx_state_t;

endpackage : acl_uart_pkg

// ==== verilog/acl_uart_reporter.sv ====
/*
  Top level: readings capture, hex conversion, UART line out
  Instances and wires only
*/
`timescale 1ns/1ps
`include "acl_uart_defs.svh"

module acl_uart_reporter (
  input  logic                    i_clk,             // 20 MHz system clock
  input  logic                    i_rst,             // Sync, active high
  input  acl_uart_pkg::readings_t i_readings,        // X, Y, Z, temp
  input  logic                    i_readings_valid,  // One-cycle pulse
  input  logic                    i_tx_go,           // Start one line
  output logic                    o_uart_tx,
  output logic                    o_line_busy
);

  localparam int c_reading_w = $bits(acl_uart_pkg::reading_t);

  logic s_clk_20mhz;
  logic s_rst_20mhz;

  acl_uart_pkg::readings_t    s_held_readings;              // Stable during a line
  acl_uart_pkg::ascii_field_t s_fields [`ACL_FIELD_COUNT];  // Hex text per reading

  // Byte strobe between feed and transmitter
  acl_uart_pkg::ascii_char_t s_tx_data;
  logic                      s_tx_valid;
  logic                      s_tx_ready;
  logic                      s_line_busy;

  assign s_clk_20mhz = i_clk;
  assign s_rst_20mhz = i_rst;
  assign o_line_busy = s_line_busy;

  //----------------------------------------------------------
  // Capture and conversion
  //----------------------------------------------------------
  acl_readings_hold u_readings_hold (
    .i_clk            (s_clk_20mhz),
    .i_rst            (s_rst_20mhz),
    .i_readings       (i_readings),
    .i_readings_valid (i_readings_valid),
    .i_line_busy      (s_line_busy),       // Freeze during a line
    .o_readings       (s_held_readings)
  );

  // One converter per reading, field 0 is X
  for (genvar gi = 0; gi < `ACL_FIELD_COUNT; gi++) begin : g_hex
    reading_hex_ascii u_reading_hex_ascii (
      .i_clk     (s_clk_20mhz),
      .i_rst     (s_rst_20mhz),
      .i_reading (s_held_readings[gi*c_reading_w +: c_reading_w]),
      .o_field   (s_fields[gi])
    );
  end : g_hex

  //----------------------------------------------------------
  // UART line out
  //----------------------------------------------------------
  uart_line_feed u_uart_line_feed (
    .i_clk       (s_clk_20mhz),
    .i_rst       (s_rst_20mhz),
    .i_fields    (s_fields),
    .i_tx_go     (i_tx_go),
    .o_tx_data   (s_tx_data),
    .o_tx_valid  (s_tx_valid),
    .i_tx_ready  (s_tx_ready),
    .o_line_busy (s_line_busy)
  );

  uart_tx_serial u_uart_tx_serial (
    .i_clk      (s_clk_20mhz),
    .i_rst      (s_rst_20mhz),
    .i_tx_data  (s_tx_data),
    .i_tx_valid (s_tx_valid),
    .o_tx_ready (s_tx_ready),
    .o_uart_tx  (o_uart_tx)          // 8N1 at ACL_BAUD
  );

endmodule : acl_uart_reporter

// ==== verilog/reading_hex_ascii.sv ====
/*
  One 16-bit reading to four upper-case hex ASCII chars
  Output registered, most significant nibble first
*/
`timescale 1ns/1ps
`include "acl_uart_defs.svh"

module reading_hex_ascii (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  acl_uart_pkg::reading_t    i_reading,  // Held reading
  output acl_uart_pkg::ascii_field_t o_field     // First char in top byte
);

  localparam acl_uart_pkg::ascii_char_t c_ascii_zero = 8'h30;  // '0'
  localparam acl_uart_pkg::ascii_char_t c_ascii_a_off = 8'h37; // 'A' minus 10

  acl_uart_pkg::ascii_field_t s_field_next;

  // Nibble to character, 0-9 then A-F
  function automatic acl_uart_pkg::ascii_char_t nibble_to_ascii(input logic [3:0] i_nibble);
    if (i_nibble < 4'd10) begin
      return c_ascii_zero + {4'd0, i_nibble};
    end else begin
      return c_ascii_a_off + {4'd0, i_nibble};
    end
  endfunction

  //----------------------------------------------------------
  // Conversion
  //----------------------------------------------------------
  // Nibble i maps to byte i, so the top nibble lands in the top byte
  always_comb begin : p_convert
    for (int i = 0; i < `ACL_HEX_DIGITS; i++) begin
      s_field_next[i*8 +: 8] = nibble_to_ascii(i_reading[i*4 +: 4]);
    end
  end : p_convert

  always_ff @(posedge i_clk) begin : p_field_reg
    if (i_rst) begin
      o_field <= {`ACL_HEX_DIGITS{c_ascii_zero}};  // Reads as "0000"
    end else begin
      o_field <= s_field_next;                     // One cycle behind input
    end
  end : p_field_reg

endmodule : reading_hex_ascii

// ==== verilog/uart_line_feed.sv ====
/*
  UART line feed: latches the text line on a go pulse
  Hands 21 bytes to the transmitter over a valid/ready strobe
*/
`timescale 1ns/1ps
`include "acl_uart_defs.svh"

module uart_line_feed (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  acl_uart_pkg::ascii_field_t i_fields [`ACL_FIELD_COUNT], // Field 0 sent first
  input  logic                       i_tx_go,     // Start one line
  output acl_uart_pkg::ascii_char_t  o_tx_data,   // Byte on offer
  output logic                       o_tx_valid,
  input  logic                       i_tx_ready,
  output logic                       o_line_busy  // High while a line is out
);

  localparam int c_line_bits = `ACL_LINE_BYTES * 8;
  localparam int c_field_bits = `ACL_HEX_DIGITS * 8;
  localparam int c_field_stride = c_field_bits + 8;              // Field plus space
  localparam int c_idx_w = $clog2(`ACL_LINE_BYTES);
  localparam logic [c_idx_w-1:0] c_last_idx = c_idx_w'(`ACL_LINE_BYTES - 1);

  localparam acl_uart_pkg::ascii_char_t c_space = 8'h20;
  localparam acl_uart_pkg::ascii_char_t c_cr = 8'h0D;
  localparam acl_uart_pkg::ascii_char_t c_lf = 8'h0A;

  acl_uart_pkg::feed_state_t s_state;
  acl_uart_pkg::uart_line_t  s_line_next;  // Assembled from live fields
  acl_uart_pkg::uart_line_t  s_line;       // Latched line, shifts left per byte
  logic [c_idx_w-1:0]        s_byte_idx;   // Bytes accepted so far
  logic                      s_accept;

  //----------------------------------------------------------
  // Line assembly
  //----------------------------------------------------------
  always_comb begin : p_assemble
    s_line_next = '0;
    for (int f = 0; f < `ACL_FIELD_COUNT; f++) begin
      s_line_next[c_line_bits-1 - f*c_field_stride -: c_field_bits] = i_fields[f];
      // Separator after every field but the last
      if (f < `ACL_FIELD_COUNT - 1) begin
        s_line_next[c_line_bits-1 - f*c_field_stride - c_field_bits -: 8] = c_space;
      end
    end
    s_line_next[15:0] = {c_cr, c_lf};  // Line end
  end : p_assemble

  assign s_accept = o_tx_valid & i_tx_ready;        // Handshake
  assign o_tx_data = s_line[c_line_bits-1 -: 8];    // Always the top byte
  assign o_line_busy = (s_state != acl_uart_pkg::feed_idle);

  // Latched text, payload only
  always_ff @(posedge i_clk) begin : p_line_reg
    if ((s_state == acl_uart_pkg::feed_idle) && i_tx_go) begin
      s_line <= s_line_next;           // Latch in the go cycle
    end else if (s_accept) begin
      s_line <= s_line << 8;           // Next byte to the top
    end
  end : p_line_reg

  //----------------------------------------------------------
  // Byte sequencer FSM
  //----------------------------------------------------------
  always_ff @(posedge i_clk) begin : p_feed_fsm
    if (i_rst) begin
      s_state <= acl_uart_pkg::feed_idle;
      o_tx_valid <= 1'b0;
      s_byte_idx <= '0;
    end else begin
      case (s_state)
        acl_uart_pkg::feed_idle: begin
          if (i_tx_go) s_state <= acl_uart_pkg::feed_load;  // Busy from next cycle
        end
        acl_uart_pkg::feed_load: begin
          s_byte_idx <= '0;
          o_tx_valid <= 1'b1;                  // Offer first byte
          s_state <= acl_uart_pkg::feed_send;
        end
        acl_uart_pkg::feed_send: begin
          if (s_accept) begin
            if (s_byte_idx == c_last_idx) begin
              o_tx_valid <= 1'b0;              // Last byte gone
              s_state <= acl_uart_pkg::feed_wait;
            end else begin
              s_byte_idx <= s_byte_idx + 1'b1;
            end
          end
        end
        acl_uart_pkg::feed_wait: begin
          // Hold busy until the final stop bit is out
          if (i_tx_ready) s_state <= acl_uart_pkg::feed_idle;
        end
        default: s_state <= acl_uart_pkg::feed_idle;
      endcase
    end
  end : p_feed_fsm

endmodule : uart_line_feed

// ==== verilog/uart_tx_serial.sv ====
/*
  8N1 UART transmitter, baud from a clock divisor
  Plain valid/ready byte strobe, ready only while idle
*/
`timescale 1ns/1ps
`include "acl_uart_defs.svh"

module uart_tx_serial (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  acl_uart_pkg::ascii_char_t i_tx_data,   // Byte to send
  input  logic                      i_tx_valid,
  output logic                      o_tx_ready,  // High in idle only
  output logic                      o_uart_tx    // Serial line, idles high
);

  localparam int c_baud_w = $clog2(`ACL_BAUD_DIV);
  localparam logic [c_baud_w-1:0] c_baud_last = c_baud_w'(`ACL_BAUD_DIV - 1);

  acl_uart_pkg::tx_state_t   s_state;
  logic [c_baud_w-1:0]       s_baud_cnt;   // Clocks within one bit
  logic                      s_baud_end;   // Last clock of a bit
  logic [2:0]                s_bit_cnt;    // Data bit index
  acl_uart_pkg::ascii_char_t s_shift;      // LSB goes out next

  assign o_tx_ready = (s_state == acl_uart_pkg::tx_idle);
  assign s_baud_end = (s_baud_cnt == c_baud_last);

  //----------------------------------------------------------
  // Baud counter
  //----------------------------------------------------------
  always_ff @(posedge i_clk) begin : p_baud
    if (i_rst) begin
      s_baud_cnt <= '0;
    end else if ((s_state == acl_uart_pkg::tx_idle) || s_baud_end) begin
      s_baud_cnt <= '0;                  // Restart per bit
    end else begin
      s_baud_cnt <= s_baud_cnt + 1'b1;
    end
  end : p_baud

  // Data shift register, payload only
  always_ff @(posedge i_clk) begin : p_shift
    if (o_tx_ready && i_tx_valid) begin
      s_shift <= i_tx_data;              // Load on acceptance
    end else if (s_baud_end && (s_state != acl_uart_pkg::tx_stop)) begin
      s_shift <= s_shift >> 1;           // Start and data bit ends
    end
  end : p_shift

  //----------------------------------------------------------
  // Bit FSM
  //----------------------------------------------------------
  always_ff @(posedge i_clk) begin : p_tx_fsm
    if (i_rst) begin
      s_state <= acl_uart_pkg::tx_idle;
      s_bit_cnt <= '0;
      o_uart_tx <= 1'b1;                 // Line idles high
    end else begin
      case (s_state)
        acl_uart_pkg::tx_idle: begin
          o_uart_tx <= 1'b1;
          if (i_tx_valid) begin
            o_uart_tx <= 1'b0;           // Start bit from acceptance
            s_state <= acl_uart_pkg::tx_start;
          end
        end
        acl_uart_pkg::tx_start: begin
          if (s_baud_end) begin
            o_uart_tx <= s_shift[0];     // Data bit 0
            s_bit_cnt <= '0;
            s_state <= acl_uart_pkg::tx_data;
          end
        end
        acl_uart_pkg::tx_data: begin
          if (s_baud_end) begin
            if (s_bit_cnt == 3'd7) begin
              o_uart_tx <= 1'b1;         // Stop bit
              s_state <= acl_uart_pkg::tx_stop;
            end else begin
              o_uart_tx <= s_shift[0];
              s_bit_cnt <= s_bit_cnt + 1'b1;
            end
          end
        end
        acl_uart_pkg::tx_stop: begin
          if (s_baud_end) s_state <= acl_uart_pkg::tx_idle;  // Ready again
        end
        default: s_state <= acl_uart_pkg::tx_idle;
      endcase
    end
  end : p_tx_fsm

endmodule : uart_tx_serial
